/* common/arb_macros.svh */
`ifndef ARB_MACROS_SVH
`define ARB_MACROS_SVH

// sizing of the two-level round-robin arbiter

// total number of requesters
`define ARB_WIDTH 16

// number of groups at the upper level
`define ARB_GROUP_NUM 4

// members per group
// must divide ARB_WIDTH evenly
`define ARB_GROUP_WIDTH (`ARB_WIDTH / `ARB_GROUP_NUM)

`endif

/* common/arb_pkg.sv */
`include "arb_macros.svh"

// types for the full-width arbiter vectors
package arb_pkg;

    // one bit per requester
    // used for both the request and the one-hot grant
    typedef logic [`ARB_WIDTH-1:0] req_vec_t;

endpackage

/* common/tree_pkg.sv */
`include "arb_macros.svh"

// types describing how the requesters split into groups
package tree_pkg;

    // members of one group
    // slice of the full request vector
    typedef logic [`ARB_GROUP_WIDTH-1:0] member_vec_t;

    // one bit per group
    // used for group requests and the group grant
    typedef logic [`ARB_GROUP_NUM-1:0] group_vec_t;

endpackage

/* common/arb_if.sv */
// request and grant bundle of a single round-robin arbiter
interface arb_if #(
    parameter int WIDTH = 4
);

    // one bit per requester
    logic [WIDTH-1:0] request;

    // one-hot, same cycle as request
    logic [WIDTH-1:0] grant;

    // high when any request bit is set
    logic any_grant;

    // the current winner was taken, pointer may move
    logic priority_en;

    modport arbiter (
        input  request,
        input  priority_en,
        output grant,
        output any_grant
    );

    modport client (
        output request,
        output priority_en,
        input  grant,
        input  any_grant
    );

endinterface

/* rr_arbiter/rr_arbiter.sv */
// round-robin arbiter built from thermometer codes
// grant is combinational, the priority pointer moves only on an accepted grant
module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input logic clk,
    input logic reset,
    arb_if.arbiter port
);

    typedef logic [WIDTH-1:0] vec_t;

    // priority pointer
    // set bits mark indices above the last accepted winner
    vec_t pointer;

    vec_t masked_request;
    vec_t thermo_all;
    vec_t thermo_masked;
    vec_t thermo_sel;
    vec_t edge_mask;

    logic masked_hit;
    logic load_pointer;

    // the edge extraction below needs at least two bits
    if (WIDTH < 2) begin : g_width_check
        $error("rr_arbiter needs WIDTH of two or more");
    end

    // bit i is set when any of bits 0..i is set
    function automatic vec_t thermo(input vec_t v);
        vec_t t;
        t[0] = v[0];
        for (int i = 1; i < WIDTH; i++) begin
            t[i] = t[i-1] | v[i];
        end
        return t;
    endfunction

    // only requests above the last winner
    assign masked_request = port.request & pointer;

    assign thermo_all    = thermo(port.request);
    assign thermo_masked = thermo(masked_request);

    // top bit of a thermometer code tells whether the code is non-empty
    assign masked_hit = thermo_masked[WIDTH-1];

    // wrap around to the lowest requester when nothing above the pointer asks
    assign thermo_sel = masked_hit ? thermo_masked : thermo_all;

    // shifted code covers everything above the winner
    assign edge_mask = {thermo_sel[WIDTH-2:0], 1'b0};

    // the single rising edge of the code is the winner
    assign port.grant = thermo_sel ^ edge_mask;

    assign port.any_grant = thermo_all[WIDTH-1];

    assign load_pointer = port.priority_en & port.any_grant;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // all ones: lowest index wins first
            pointer <= '1;
        end else if (load_pointer) begin
            pointer <= edge_mask;
        end
    end

    // at most one winner per cycle
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(port.grant)
    ) else $error("rr_arbiter grant is not one-hot: %b", port.grant);

    // never grant a requester that does not ask
    a_grant_in_request: assert property (
        @(posedge clk) disable iff (reset)
        (port.grant & ~port.request) == '0
    ) else $error("rr_arbiter grant %b outside request %b", port.grant, port.request);

    // any request must produce a grant
    a_any_grant: assert property (
        @(posedge clk) disable iff (reset)
        port.any_grant == (|port.request)
    ) else $error("rr_arbiter any_grant does not match request");

endmodule

/* design/arbiter_tree.sv */
`include "arb_macros.svh"

// two-level round-robin arbiter
// member arbiters pick one requester per group, a group arbiter picks the group
module arbiter_tree (
    input  logic              clk,
    input  logic              reset,
    input  arb_pkg::req_vec_t request,
    input  logic              accept,
    output arb_pkg::req_vec_t grant,
    output logic              any_grant
);

    // groups that have at least one request
    tree_pkg::group_vec_t group_has_req;

    // winning group, one-hot
    tree_pkg::group_vec_t group_grant;

    if (`ARB_GROUP_WIDTH * `ARB_GROUP_NUM != `ARB_WIDTH) begin : g_size_check
        $error("ARB_WIDTH must split evenly into ARB_GROUP_NUM groups");
    end

    // upper level
    arb_if #(
        .WIDTH (`ARB_GROUP_NUM)
    ) group_if ();

    for (genvar g = 0; g < `ARB_GROUP_NUM; g++) begin : g_member

        tree_pkg::member_vec_t member_req;
        tree_pkg::member_vec_t member_grant;

        arb_if #(
            .WIDTH (`ARB_GROUP_WIDTH)
        ) member_if ();

        // slice of the full request vector
        assign member_req = request[g*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH];

        assign member_if.request = member_req;

        // member pointer moves only when its group wins and the winner is taken
        assign member_if.priority_en = accept & group_grant[g];

        rr_arbiter #(
            .WIDTH (`ARB_GROUP_WIDTH)
        ) i_member_arb (
            .clk   (clk),
            .reset (reset),
            .port  (member_if.arbiter)
        );

        // any member asking makes the group a candidate
        assign group_has_req[g] = member_if.any_grant;

        // drop the local winner of groups that lose at the upper level
        assign member_grant = member_if.grant & {`ARB_GROUP_WIDTH{group_grant[g]}};

        assign grant[g*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH] = member_grant;

    end

    assign group_if.request     = group_has_req;
    assign group_if.priority_en = accept;

    rr_arbiter #(
        .WIDTH (`ARB_GROUP_NUM)
    ) i_group_arb (
        .clk   (clk),
        .reset (reset),
        .port  (group_if.arbiter)
    );

    assign group_grant = group_if.grant;
    assign any_grant   = group_if.any_grant;

    // the assembled grant stays one-hot and inside the request
    a_tree_onehot: assert property (
        @(posedge clk) disable iff (reset)
        any_grant |-> ($onehot(grant) && ((grant & ~request) == '0))
    ) else $error("arbiter_tree grant %h invalid for request %h", grant, request);

    // no request anywhere means no grant anywhere
    a_tree_idle: assert property (
        @(posedge clk) disable iff (reset)
        (request == '0) |-> (!any_grant && (grant == '0))
    ) else $error("arbiter_tree granted with no request");

    // back-pressure freezes both levels
    // an unchanged request then gives an unchanged grant
    a_tree_hold: assert property (
        @(posedge clk) disable iff (reset)
        !accept ##1 $stable(request) |-> $stable(grant)
    ) else $error("arbiter_tree grant changed while accept was low");

endmodule

/* testbench/tb_arbiter_tree.sv */
`include "arb_macros.svh"

// testbench for the two-level round-robin arbiter
module tb_arbiter_tree;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 16;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_RANDOM   = 200;

    localparam logic [31:0] LFSR_SEED = 32'hd68c1094;
    // x^32 + x^22 + x^2 + x + 1 in Galois form
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    typedef struct {
        arb_pkg::req_vec_t request;
        logic              accept;
        arb_pkg::req_vec_t grant;
    } entry_t;

    logic              clk;
    logic              reset;
    arb_pkg::req_vec_t request;
    logic              accept;
    arb_pkg::req_vec_t grant;
    logic              any_grant;

    // directed stimulus with expected grants
    entry_t directed[$];
    logic   table_ready;

    int grant_errors;
    int any_errors;

    logic [31:0] lfsr_state;

    // reference priorities: last accepted winner, -1 when none since reset
    int group_last;
    int member_last[`ARB_GROUP_NUM];

    arbiter_tree i_dut (
        .clk       (clk),
        .reset     (reset),
        .request   (request),
        .accept    (accept),
        .grant     (grant),
        .any_grant (any_grant)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? LFSR_TAPS : 32'h0);
    endfunction

    // one random bit per LFSR step
    task automatic draw_bit(output logic value);
        value = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
    endtask

    // first requester above last, else the lowest one, -1 with no request
    function automatic int rr_pick(input logic [31:0] req, input int width, input int last);
        for (int i = last + 1; i < width; i++) begin
            if (req[i]) begin
                return i;
            end
        end
        for (int i = 0; i < width; i++) begin
            if (req[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic model_reset();
        group_last = -1;
        for (int g = 0; g < `ARB_GROUP_NUM; g++) begin
            member_last[g] = -1;
        end
    endtask

    // expected grant for this cycle, then the priority update at the next edge
    task automatic model_step(
        input  arb_pkg::req_vec_t req,
        input  logic              acc,
        output arb_pkg::req_vec_t expected
    );
        tree_pkg::group_vec_t  group_req;
        tree_pkg::member_vec_t member_req;
        int                    g_win;
        int                    m_win;
        expected = '0;
        for (int g = 0; g < `ARB_GROUP_NUM; g++) begin
            group_req[g] = |req[g*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH];
        end
        g_win = rr_pick(32'(group_req), `ARB_GROUP_NUM, group_last);
        if (g_win >= 0) begin
            member_req = req[g_win*`ARB_GROUP_WIDTH +: `ARB_GROUP_WIDTH];
            m_win = rr_pick(32'(member_req), `ARB_GROUP_WIDTH, member_last[g_win]);
            expected[g_win*`ARB_GROUP_WIDTH + m_win] = 1'b1;
            // losing groups keep their member priority
            if (acc) begin
                group_last = g_win;
                member_last[g_win] = m_win;
            end
        end
    endtask

    task automatic check_grant(
        input arb_pkg::req_vec_t expected,
        input arb_pkg::req_vec_t actual,
        input int                entry
    );
        if (actual !== expected) begin
            grant_errors++;
            $display("Fail grant at entry %0d: expected %h, actual %h",
                     entry, expected, actual);
        end
    endtask

    task automatic check_any(
        input logic expected,
        input logic actual,
        input int   entry
    );
        if (actual !== expected) begin
            any_errors++;
            $display("Fail any_grant at entry %0d: expected %h, actual %h",
                     entry, expected, actual);
        end
    endtask

    task automatic add_entry(
        input arb_pkg::req_vec_t req,
        input logic              acc,
        input arb_pkg::req_vec_t exp_grant
    );
        entry_t e;
        e.request = req;
        e.accept  = acc;
        e.grant   = exp_grant;
        directed.push_back(e);
    endtask

    task automatic load_table();
        // single requesters, accept low keeps the reset priority
        add_entry(16'h0001, 1'b0, 16'h0001);
        add_entry(16'h0020, 1'b0, 16'h0020);
        add_entry(16'h0400, 1'b0, 16'h0400);
        add_entry(16'h8000, 1'b0, 16'h8000);
        add_entry(16'h0008, 1'b0, 16'h0008);
        // idle
        add_entry(16'h0000, 1'b0, 16'h0000);
        add_entry(16'h0000, 1'b1, 16'h0000);
        // group 0 full, members rotate 0 1 2 3 0
        add_entry(16'h000f, 1'b1, 16'h0001);
        add_entry(16'h000f, 1'b1, 16'h0002);
        add_entry(16'h000f, 1'b1, 16'h0004);
        add_entry(16'h000f, 1'b1, 16'h0008);
        add_entry(16'h000f, 1'b1, 16'h0001);
        // two members in each group
        // group priority starts after group 0, member 0 of group 0 was last
        add_entry(16'h3333, 1'b1, 16'h0010);
        add_entry(16'h3333, 1'b1, 16'h0100);
        add_entry(16'h3333, 1'b1, 16'h1000);
        add_entry(16'h3333, 1'b1, 16'h0002);
        // second round, only the winning group had moved its member pointer
        add_entry(16'h3333, 1'b1, 16'h0020);
        add_entry(16'h3333, 1'b1, 16'h0200);
        add_entry(16'h3333, 1'b1, 16'h2000);
        add_entry(16'h3333, 1'b1, 16'h0001);
        // back-pressure holds the winner
        add_entry(16'h0f06, 1'b0, 16'h0400);
        add_entry(16'h0f06, 1'b0, 16'h0400);
        add_entry(16'h0f06, 1'b0, 16'h0400);
        add_entry(16'h0f06, 1'b1, 16'h0400);
        add_entry(16'h0f06, 1'b1, 16'h0002);
        add_entry(16'h0f06, 1'b0, 16'h0800);
        add_entry(16'h0f06, 1'b0, 16'h0800);
        add_entry(16'h0f06, 1'b1, 16'h0800);
        add_entry(16'h0000, 1'b0, 16'h0000);
    endtask

    // drive one entry, sample just before the next rising edge
    task automatic apply_entry(
        input arb_pkg::req_vec_t req,
        input logic              acc,
        input arb_pkg::req_vec_t exp_grant,
        input int                entry
    );
        request = req;
        accept  = acc;
        #(SAMPLE_DELAY);
        check_grant(exp_grant, grant, entry);
        check_any(|req, any_grant, entry);
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    initial begin
        arb_pkg::req_vec_t model_grant;
        arb_pkg::req_vec_t rand_req;
        logic              rand_acc;
        logic              bit_val;
        int                entry;

        clk          = 1'b0;
        reset        = 1'b1;
        request      = '0;
        accept       = 1'b0;
        grant_errors = 0;
        any_errors   = 0;
        lfsr_state   = LFSR_SEED;
        table_ready  = 1'b0;

        model_reset();
        load_table();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;

        entry = 0;
        foreach (directed[i]) begin
            // model follows the directed phase so the random phase starts in step
            model_step(directed[i].request, directed[i].accept, model_grant);
            apply_entry(directed[i].request, directed[i].accept, directed[i].grant, entry);
            entry++;
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            for (int b = 0; b < `ARB_WIDTH; b++) begin
                draw_bit(bit_val);
                rand_req[b] = bit_val;
            end
            draw_bit(rand_acc);
            model_step(rand_req, rand_acc, model_grant);
            apply_entry(rand_req, rand_acc, model_grant, entry);
            entry++;
        end

        $display("errors: grant %0d, any_grant %0d", grant_errors, any_errors);
        if (grant_errors == 0 && any_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        int limit_cycles;
        wait (table_ready === 1'b1);
        limit_cycles = directed.size() + NUM_RANDOM + 10;
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the run did not complete within %0d clock cycles", limit_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tb.f */
+incdir+common
common/arb_pkg.sv
common/tree_pkg.sv
common/arb_if.sv
rr_arbiter/rr_arbiter.sv
design/arbiter_tree.sv
testbench/tb_arbiter_tree.sv

/* Makefile */
# Verilator flow for the two-level round-robin arbiter

TOP := tb_arbiter_tree

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f tb.f --top-module arbiter_tree

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
